// ==== axil_csr_port.sv ====
// AXI4-Lite slave port that captures CSR writes, sequences responses and registers read data
`timescale 1ns/100ps

module axil_csr_port (
    input logic clk,
    input logic reset_n,

    // Write address channel
    input host_chan_pkg::t_csr_addr s_awaddr,
    input logic s_awvalid,
    output logic s_awready,

    // Write data channel
    input host_chan_pkg::t_csr_data s_wdata,
    input host_chan_pkg::t_csr_strb s_wstrb,
    input logic s_wvalid,
    output logic s_wready,

    // Write response channel
    output logic s_bvalid,
    output host_chan_pkg::t_axi_resp s_bresp,
    input logic s_bready,

    // Read address channel
    input host_chan_pkg::t_csr_addr s_araddr,
    input logic s_arvalid,
    output logic s_arready,

    // Read data channel
    output logic s_rvalid,
    output host_chan_pkg::t_csr_data s_rdata,
    output host_chan_pkg::t_axi_resp s_rresp,
    input logic s_rready,

    // Read lookup in the readback block
    output host_chan_pkg::t_csr_word_addr rd_word_addr,
    input host_chan_pkg::t_csr_data rd_data,
    input logic rd_err,

    // Decoded writes toward the decoder
    csr_wr_if.source wr
);
    import host_chan_pkg::*;
`include "host_chan_settings.svh"

    // Goes high one cycle after reset so that the ready signals stay low during reset
    logic live;

    // Capture flags for the two write channels, which may arrive in either order
    logic aw_held;
    logic w_held;
    logic aw_hs;
    logic w_hs;
    logic ar_hs;

    // Offsets from the block base
    t_csr_addr aw_off;
    t_csr_addr ar_off;

    // Captured write payload
    t_csr_word_addr wr_addr_q;
    t_csr_data wr_data_q;
    t_csr_strb wr_strb_q;
    logic wr_pulse;

    assign aw_off = s_awaddr - t_csr_addr'(`HC_CSR_BASE_ADDR);
    assign ar_off = s_araddr - t_csr_addr'(`HC_CSR_BASE_ADDR);

    // A pending response blocks both write channels
    assign s_awready = live & ~aw_held & ~s_bvalid;
    assign s_wready = live & ~w_held & ~s_bvalid;
    assign s_arready = live & ~s_rvalid;

    assign aw_hs = s_awvalid & s_awready;
    assign w_hs = s_wvalid & s_wready;
    assign ar_hs = s_arvalid & s_arready;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            live <= 1'b0;
        end
        else
        begin
            live <= 1'b1;
        end
    end

    // Payload registers load on their own handshake and carry no reset
    always_ff @(posedge clk)
    begin
        if (aw_hs)
        begin
            wr_addr_q <= aw_off[`HC_CSR_ADDR_W-1:2];
        end
        if (w_hs)
        begin
            wr_data_q <= s_wdata;
            wr_strb_q <= s_wstrb;
        end
    end

    // Write sequencing: once both halves are in, pulse the decoder and raise the response
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            aw_held <= 1'b0;
            w_held <= 1'b0;
            wr_pulse <= 1'b0;
            s_bvalid <= 1'b0;
        end
        else
        begin
            if (s_bvalid && s_bready)
            begin
                s_bvalid <= 1'b0;
            end
            if ((aw_held || aw_hs) && (w_held || w_hs))
            begin
                aw_held <= 1'b0;
                w_held <= 1'b0;
                wr_pulse <= 1'b1;
                s_bvalid <= 1'b1;
            end
            else
            begin
                wr_pulse <= 1'b0;
                aw_held <= aw_held | aw_hs;
                w_held <= w_held | w_hs;
            end
        end
    end

    // Unmapped writes are dropped by the decoder, so every write answers OKAY
    assign s_bresp = OKAY;

    assign wr.valid = wr_pulse;
    assign wr.word_addr = wr_addr_q;
    assign wr.data = wr_data_q;
    assign wr.strb = wr_strb_q;

    // Read lookup is combinational from the incoming address
    assign rd_word_addr = ar_off[`HC_CSR_ADDR_W-1:2];

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            s_rvalid <= 1'b0;
        end
        else if (ar_hs)
        begin
            s_rvalid <= 1'b1;
        end
        else if (s_rready)
        begin
            s_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (ar_hs)
        begin
            s_rdata <= rd_data;
            s_rresp <= rd_err ? SLVERR : OKAY;
        end
    end

    // A write response stays up until the master takes it
    assert property (@(posedge clk) disable iff (!reset_n)
        s_bvalid && !s_bready |=> s_bvalid);

    // The decoder sees each write exactly once
    assert property (@(posedge clk) disable iff (!reset_n)
        wr.valid |=> !wr.valid);

endmodule

// ==== csr_wr_if.sv ====
// CSR write channel carrying one decoded register write from the bus port to the decoder
`timescale 1ns/100ps

interface csr_wr_if;
    import host_chan_pkg::*;

    // One-cycle pulse marking a complete write
    logic valid;

    // Word address relative to the block base
    t_csr_word_addr word_addr;

    // Write data and its byte strobes, as received from the bus
    t_csr_data data;
    t_csr_strb strb;

    // The bus port produces writes
    modport source (
        output valid,
        output word_addr,
        output data,
        output strb
    );

    // The decoder consumes them and never stalls
    modport sink (
        input valid,
        input word_addr,
        input data,
        input strb
    );

endinterface

// ==== hc_csr_decode.sv ====
// Host-channel CSR decoder that turns register writes into the broadcast engine state
`timescale 1ns/100ps

module hc_csr_decode (
    input logic clk,
    input logic reset_n,

    // Decoded writes from the bus port
    csr_wr_if.sink wr,

    // State broadcast to the engine and the readback block
    output host_chan_pkg::t_hc_csrs csr
);
    import host_chan_pkg::*;
`include "host_chan_settings.svh"

    // A write counts only when every byte lane is enabled
    logic wr_ok;

    logic en_q;
    logic en_user_q;
    t_frame_addr ctrl_frame_q;
    logic ctrl_frame_valid_q;
    t_frame_addr read_frame_q;
    t_frame_addr write_frame_q;
    t_hc_enable_test enable_test_q;

    assign wr_ok = wr.valid && (wr.strb == '1);

    // Exact word match for a 32-bit register at byte offset off
    function automatic logic match32(input t_csr_addr off);
        return wr_ok && (wr.word_addr == off[`HC_CSR_ADDR_W-1:2]);
    endfunction

    // A 64-bit register arrives as two words, so the low word-address bit is ignored
    function automatic logic match64(input t_csr_addr off);
        t_csr_word_addr a;
        a = wr.word_addr;
        a[0] = 1'b0;
        return wr_ok && (a == off[`HC_CSR_ADDR_W-1:2]);
    endfunction

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            en_q <= `HC_EN_RESET;
            en_user_q <= `HC_EN_RESET;
        end
        else if (match32(`HC_CSR_EN))
        begin
            en_q <= wr.data[0];
            en_user_q <= wr.data[1];
        end
    end

    // Frames shift in 32 bits at a time, high half first, so the low write completes them
    always_ff @(posedge clk)
    begin
        if (match64(`HC_CSR_CTRL_FRAME))
        begin
            ctrl_frame_q <= t_frame_addr'({ctrl_frame_q, wr.data});
        end
        if (match64(`HC_CSR_READ_FRAME))
        begin
            read_frame_q <= t_frame_addr'({read_frame_q, wr.data});
        end
        if (match64(`HC_CSR_WRITE_FRAME))
        begin
            write_frame_q <= t_frame_addr'({write_frame_q, wr.data});
        end
    end

    // The control frame is valid only after its low half, the second of the pair, lands
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            ctrl_frame_valid_q <= 1'b0;
        end
        else if (match64(`HC_CSR_CTRL_FRAME))
        begin
            ctrl_frame_valid_q <= ~wr.word_addr[0];
        end
    end

    // Test start is a pulse and drops back to zero after one cycle
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            enable_test_q <= '0;
        end
        else if (match32(`HC_CSR_ENABLE_TEST))
        begin
            enable_test_q <= wr.data[`HC_ENABLE_TEST_W-1:0];
        end
        else
        begin
            enable_test_q <= '0;
        end
    end

    assign csr = '{
        hc_en: en_q,
        hc_en_user_channel: en_user_q,
        hc_ctrl_frame: ctrl_frame_q,
        hc_ctrl_frame_valid: ctrl_frame_valid_q,
        hc_read_frame: read_frame_q,
        hc_write_frame: write_frame_q,
        hc_enable_test: enable_test_q
    };

    // Consumers rely on the test request never lasting two cycles
    assert property (@(posedge clk) disable iff (!reset_n)
        csr.hc_enable_test != '0 |=> csr.hc_enable_test == '0);

endmodule

// ==== hc_csr_readback.sv ====
// Host-channel CSR readback that selects a register word and counts test pulses
`timescale 1ns/100ps

module hc_csr_readback (
    input logic clk,
    input logic reset_n,

    // Current engine state from the decoder
    input host_chan_pkg::t_hc_csrs csr,

    // Lookup from the bus port
    input host_chan_pkg::t_csr_word_addr rd_word_addr,
    output host_chan_pkg::t_csr_data rd_data,
    output logic rd_err
);
    import host_chan_pkg::*;
`include "host_chan_settings.svh"

    t_test_count test_count_q;

    // One count per cycle with a nonzero mask, wrapping at the top
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            test_count_q <= '0;
        end
        else if (csr.hc_enable_test != '0)
        begin
            test_count_q <= test_count_q + 1'b1;
        end
    end

    always_comb
    begin
        rd_data = '0;
        rd_err = 1'b0;
        case ({rd_word_addr, 2'b00})
            `HC_CSR_EN:
                // Valid flag of the control frame sits next to the enables
                rd_data = t_csr_data'({csr.hc_ctrl_frame_valid,
                                       csr.hc_en_user_channel,
                                       csr.hc_en});
            `HC_CSR_CTRL_FRAME:
                rd_data = csr.hc_ctrl_frame[31:0];
            `HC_CSR_CTRL_FRAME + 8'h4:
                rd_data = csr.hc_ctrl_frame[63:32];
            `HC_CSR_READ_FRAME:
                rd_data = csr.hc_read_frame[31:0];
            `HC_CSR_READ_FRAME + 8'h4:
                rd_data = csr.hc_read_frame[63:32];
            `HC_CSR_WRITE_FRAME:
                rd_data = csr.hc_write_frame[31:0];
            `HC_CSR_WRITE_FRAME + 8'h4:
                rd_data = csr.hc_write_frame[63:32];
            `HC_CSR_ENABLE_TEST:
                // The mask is a pulse, so there is nothing to read back
                rd_data = '0;
            `HC_CSR_TEST_COUNT:
                rd_data = test_count_q;
            default:
                rd_err = 1'b1;
        endcase
    end

endmodule

// ==== host_chan_csr_top.f ====
+incdir+.
host_chan_pkg.sv
csr_wr_if.sv
axil_csr_port.sv
hc_csr_decode.sv
hc_csr_readback.sv
host_chan_csr_top.sv
tb_host_chan_csr.sv

// ==== host_chan_csr_top.sv ====
// Host-channel CSR top level joining the AXI4-Lite port, the decoder and the readback block
`timescale 1ns/100ps

module host_chan_csr_top (
    input logic clk,
    input logic reset_n,

    // AXI4-Lite slave
    input host_chan_pkg::t_csr_addr s_awaddr,
    input logic s_awvalid,
    output logic s_awready,
    input host_chan_pkg::t_csr_data s_wdata,
    input host_chan_pkg::t_csr_strb s_wstrb,
    input logic s_wvalid,
    output logic s_wready,
    output logic s_bvalid,
    output host_chan_pkg::t_axi_resp s_bresp,
    input logic s_bready,
    input host_chan_pkg::t_csr_addr s_araddr,
    input logic s_arvalid,
    output logic s_arready,
    output logic s_rvalid,
    output host_chan_pkg::t_csr_data s_rdata,
    output host_chan_pkg::t_axi_resp s_rresp,
    input logic s_rready,

    // Engine state
    output logic hc_en,
    output logic hc_en_user_channel,
    output host_chan_pkg::t_frame_addr hc_ctrl_frame,
    output logic hc_ctrl_frame_valid,
    output host_chan_pkg::t_frame_addr hc_read_frame,
    output host_chan_pkg::t_frame_addr hc_write_frame,
    output host_chan_pkg::t_hc_enable_test hc_enable_test
);
    import host_chan_pkg::*;

    t_hc_csrs csr_state;
    t_csr_word_addr rd_word_addr;
    t_csr_data rd_data;
    logic rd_err;

    csr_wr_if wr_bus ();

    axil_csr_port port0 (
        .clk(clk), .reset_n(reset_n),
        .s_awaddr(s_awaddr), .s_awvalid(s_awvalid), .s_awready(s_awready),
        .s_wdata(s_wdata), .s_wstrb(s_wstrb), .s_wvalid(s_wvalid), .s_wready(s_wready),
        .s_bvalid(s_bvalid), .s_bresp(s_bresp), .s_bready(s_bready),
        .s_araddr(s_araddr), .s_arvalid(s_arvalid), .s_arready(s_arready),
        .s_rvalid(s_rvalid), .s_rdata(s_rdata), .s_rresp(s_rresp), .s_rready(s_rready),
        .rd_word_addr(rd_word_addr), .rd_data(rd_data), .rd_err(rd_err),
        .wr(wr_bus.source)
    );

    hc_csr_decode decode0 (
        .clk(clk), .reset_n(reset_n),
        .wr(wr_bus.sink),
        .csr(csr_state)
    );

    hc_csr_readback readback0 (
        .clk(clk), .reset_n(reset_n),
        .csr(csr_state),
        .rd_word_addr(rd_word_addr), .rd_data(rd_data), .rd_err(rd_err)
    );

    // Break the state bundle out onto the engine ports
    assign hc_en = csr_state.hc_en;
    assign hc_en_user_channel = csr_state.hc_en_user_channel;
    assign hc_ctrl_frame = csr_state.hc_ctrl_frame;
    assign hc_ctrl_frame_valid = csr_state.hc_ctrl_frame_valid;
    assign hc_read_frame = csr_state.hc_read_frame;
    assign hc_write_frame = csr_state.hc_write_frame;
    assign hc_enable_test = csr_state.hc_enable_test;

endmodule

// ==== host_chan_pkg.sv ====
// Host-channel CSR package with the bus vector types, the response code and the state bundle
`include "host_chan_settings.svh"

package host_chan_pkg;

    // AXI4-Lite byte address and the 32-bit word address derived from it
    typedef logic [`HC_CSR_ADDR_W-1:0] t_csr_addr;
    typedef logic [`HC_CSR_WORD_ADDR_W-1:0] t_csr_word_addr;

    // Data word and its byte strobes
    typedef logic [`HC_CSR_DATA_W-1:0] t_csr_data;
    typedef logic [`HC_CSR_DATA_W/8-1:0] t_csr_strb;

    // Host memory address of a frame
    typedef logic [`HC_FRAME_W-1:0] t_frame_addr;

    // Test-start mask and the count of nonzero masks
    typedef logic [`HC_ENABLE_TEST_W-1:0] t_hc_enable_test;
    typedef logic [`HC_TEST_COUNT_W-1:0] t_test_count;

    // Only the two response codes this slave ever returns
    typedef enum logic [1:0] {
        OKAY = 2'b00,
        SLVERR = 2'b10
    } t_axi_resp;

    // State broadcast from the decoder to every consumer in the engine
    typedef struct packed {
        logic hc_en;
        logic hc_en_user_channel;
        t_frame_addr hc_ctrl_frame;
        logic hc_ctrl_frame_valid;
        t_frame_addr hc_read_frame;
        t_frame_addr hc_write_frame;
        t_hc_enable_test hc_enable_test;
    } t_hc_csrs;

endpackage

// ==== host_chan_settings.svh ====
// Host-channel CSR settings: base address, register offsets, widths and reset values
`ifndef HOST_CHAN_SETTINGS_SVH
`define HOST_CHAN_SETTINGS_SVH

// Byte address of the register block on the AXI4-Lite bus
`define HC_CSR_BASE_ADDR 0

// Bus widths
`define HC_CSR_ADDR_W 8
`define HC_CSR_DATA_W 32
`define HC_CSR_WORD_ADDR_W 6

// Byte offsets from the base; 64-bit registers take two words, low half first in the map
`define HC_CSR_EN 8'h00
`define HC_CSR_CTRL_FRAME 8'h08
`define HC_CSR_READ_FRAME 8'h10
`define HC_CSR_WRITE_FRAME 8'h18
`define HC_CSR_ENABLE_TEST 8'h20
`define HC_CSR_TEST_COUNT 8'h24

// Payload widths
`define HC_ENABLE_TEST_W 8
`define HC_FRAME_W 64
`define HC_TEST_COUNT_W 32

// Reset value of the enable bits
`define HC_EN_RESET 1'b0

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the host-channel CSR testbench with Verilator, runs it and reports the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f host_chan_csr_top.f \
    --top-module tb_host_chan_csr \
    -o sim_host_chan_csr
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/sim_host_chan_csr 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

# The testbench prints its pass line only when every check held
if grep -qx "PASS: all tests" <<< "$sim_output"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// ==== tb_host_chan_csr.sv ====
// Host-channel CSR testbench driving AXI4-Lite against a shadow register model
`timescale 1ns/100ps
`include "host_chan_settings.svh"

module tb_host_chan_csr;
    import host_chan_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;

    logic clk;
    logic reset_n;
    t_csr_addr s_awaddr;
    logic s_awvalid;
    logic s_awready;
    t_csr_data s_wdata;
    t_csr_strb s_wstrb;
    logic s_wvalid;
    logic s_wready;
    logic s_bvalid;
    t_axi_resp s_bresp;
    logic s_bready;
    t_csr_addr s_araddr;
    logic s_arvalid;
    logic s_arready;
    logic s_rvalid;
    t_csr_data s_rdata;
    t_axi_resp s_rresp;
    logic s_rready;
    logic hc_en;
    logic hc_en_user_channel;
    t_frame_addr hc_ctrl_frame;
    logic hc_ctrl_frame_valid;
    t_frame_addr hc_read_frame;
    t_frame_addr hc_write_frame;
    t_hc_enable_test hc_enable_test;

    // Shadow copy of the registers, updated when a write response is taken
    logic m_en;
    logic m_user;
    logic m_ctrl_valid;
    t_frame_addr m_ctrl;
    t_frame_addr m_read;
    t_frame_addr m_write;
    t_test_count m_count;

    int errors;
    int checks;
    int err_mark;
    logic pulse_prev;
    t_hc_enable_test pulses_seen[$];

    host_chan_csr_top dut0 (.*);

    always #50 clk = ~clk;

    // Records every nonzero test mask seen on the engine port
    always @(negedge clk)
    begin
        if (reset_n)
        begin
            if (hc_enable_test != '0)
            begin
                pulses_seen.push_back(hc_enable_test);
                if (pulse_prev)
                begin
                    errors++;
                    $display("error at %0d ns: hc_enable_test nonzero for two cycles", $time);
                end
            end
            pulse_prev = (hc_enable_test != '0);
        end
    end

    task automatic end_run();
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
        begin
            $display("PASS: all tests");
        end
        else
        begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    task automatic abort_run(input string msg);
        errors++;
        $display("error at %0d ns: %s", $time, msg);
        end_run();
    endtask

    task automatic test_done(input string name);
        $display("test %s finished with %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    task automatic check_word(input string name, input t_csr_data got, input t_csr_data exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_frame(input string name, input t_frame_addr got, input t_frame_addr exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input t_axi_resp got, input t_axi_resp exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("mismatch at %0d ns: %s got %s expected %s", $time, name,
                     got.name(), exp.name());
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("mismatch at %0d ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    function automatic t_csr_addr reg_addr(input t_csr_addr off);
        return t_csr_addr'(`HC_CSR_BASE_ADDR) + off;
    endfunction

    // Register rules: full strobes only, frames shift in 32 bits, low half marks valid
    task automatic model_write(input t_csr_addr addr, input t_csr_data data, input t_csr_strb strb);
        t_csr_addr off;
        off = addr - t_csr_addr'(`HC_CSR_BASE_ADDR);
        if (strb == '1)
        begin
            case (off)
                `HC_CSR_EN:
                begin
                    m_en = data[0];
                    m_user = data[1];
                end
                `HC_CSR_CTRL_FRAME, `HC_CSR_CTRL_FRAME + 8'h4:
                begin
                    m_ctrl = {m_ctrl[31:0], data};
                    m_ctrl_valid = (off == `HC_CSR_CTRL_FRAME);
                end
                `HC_CSR_READ_FRAME, `HC_CSR_READ_FRAME + 8'h4:
                    m_read = {m_read[31:0], data};
                `HC_CSR_WRITE_FRAME, `HC_CSR_WRITE_FRAME + 8'h4:
                    m_write = {m_write[31:0], data};
                `HC_CSR_ENABLE_TEST:
                    if (data[`HC_ENABLE_TEST_W-1:0] != '0)
                    begin
                        m_count++;
                    end
                default:
                    ;
            endcase
        end
    endtask

    // Expected read data and response for any byte address
    function automatic t_axi_resp ref_read(input t_csr_addr addr, output t_csr_data data);
        t_csr_addr off;
        off = addr - t_csr_addr'(`HC_CSR_BASE_ADDR);
        data = '0;
        case (off)
            `HC_CSR_EN: data = {29'd0, m_ctrl_valid, m_user, m_en};
            `HC_CSR_CTRL_FRAME: data = m_ctrl[31:0];
            `HC_CSR_CTRL_FRAME + 8'h4: data = m_ctrl[63:32];
            `HC_CSR_READ_FRAME: data = m_read[31:0];
            `HC_CSR_READ_FRAME + 8'h4: data = m_read[63:32];
            `HC_CSR_WRITE_FRAME: data = m_write[31:0];
            `HC_CSR_WRITE_FRAME + 8'h4: data = m_write[63:32];
            `HC_CSR_ENABLE_TEST: data = '0;
            `HC_CSR_TEST_COUNT: data = m_count;
            default: return SLVERR;
        endcase
        return OKAY;
    endfunction

    // Full write: AW and W together or data first, then B after b_delay cycles
    task automatic axil_write(input t_csr_addr addr, input t_csr_data data, input t_csr_strb strb,
                              input bit w_first, input int b_delay);
        bit aw_done;
        bit w_done;
        bit aw_take;
        bit w_take;
        int cycles;
        aw_done = 1'b0;
        w_done = 1'b0;
        cycles = 0;
        @(posedge clk);
        #1;
        s_awaddr = addr;
        s_wdata = data;
        s_wstrb = strb;
        s_wvalid = 1'b1;
        s_awvalid = !w_first;
        while (!(aw_done && w_done))
        begin
            if (cycles == TIMEOUT_CYCLES)
            begin
                abort_run("write address or data was never accepted");
            end
            @(negedge clk);
            aw_take = s_awvalid && s_awready;
            w_take = s_wvalid && s_wready;
            @(posedge clk);
            #1;
            if (aw_take)
            begin
                aw_done = 1'b1;
                s_awvalid = 1'b0;
            end
            if (w_take)
            begin
                w_done = 1'b1;
                s_wvalid = 1'b0;
            end
            // Reversed order sends the address only once the data is taken
            if (w_done && !aw_done)
            begin
                s_awvalid = 1'b1;
            end
            cycles++;
        end
        repeat (b_delay)
        begin
            @(posedge clk);
            #1;
        end
        s_bready = 1'b1;
        cycles = 0;
        @(negedge clk);
        while (!s_bvalid)
        begin
            if (cycles == TIMEOUT_CYCLES)
            begin
                abort_run("no write response arrived");
            end
            @(negedge clk);
            cycles++;
        end
        check_resp("s_bresp", s_bresp, OKAY);
        // A pending response holds off both write channels
        check_bit("s_awready", s_awready, 1'b0);
        check_bit("s_wready", s_wready, 1'b0);
        @(posedge clk);
        #1;
        s_bready = 1'b0;
        model_write(addr, data, strb);
    endtask

    task automatic axil_read(input t_csr_addr addr, input int r_delay,
                             output t_csr_data data, output t_axi_resp resp);
        int cycles;
        cycles = 0;
        @(posedge clk);
        #1;
        s_araddr = addr;
        s_arvalid = 1'b1;
        @(negedge clk);
        while (!s_arready)
        begin
            if (cycles == TIMEOUT_CYCLES)
            begin
                abort_run("read address was never accepted");
            end
            @(negedge clk);
            cycles++;
        end
        @(posedge clk);
        #1;
        s_arvalid = 1'b0;
        repeat (r_delay)
        begin
            @(posedge clk);
            #1;
        end
        s_rready = 1'b1;
        cycles = 0;
        @(negedge clk);
        while (!s_rvalid)
        begin
            if (cycles == TIMEOUT_CYCLES)
            begin
                abort_run("no read data arrived");
            end
            @(negedge clk);
            cycles++;
        end
        data = s_rdata;
        resp = s_rresp;
        // No new read address is taken while the data waits
        check_bit("s_arready", s_arready, 1'b0);
        @(posedge clk);
        #1;
        s_rready = 1'b0;
    endtask

    task automatic read_and_check(input t_csr_addr addr, input int r_delay);
        t_csr_data got;
        t_csr_data exp;
        t_axi_resp resp;
        t_axi_resp exp_resp;
        axil_read(addr, r_delay, got, resp);
        exp_resp = ref_read(addr, exp);
        check_word($sformatf("s_rdata@%02h", addr), got, exp);
        check_resp($sformatf("s_rresp@%02h", addr), resp, exp_resp);
    endtask

    task automatic check_all_regs(input int r_delay);
        int off;
        for (off = 0; off <= 'h24; off += 4)
        begin
            if (off != 4)
            begin
                read_and_check(reg_addr(t_csr_addr'(off)), r_delay);
            end
        end
    endtask

    // Engine ports against the shadow, sampled away from the clock edge
    task automatic check_state();
        @(negedge clk);
        check_bit("hc_en", hc_en, m_en);
        check_bit("hc_en_user_channel", hc_en_user_channel, m_user);
        check_bit("hc_ctrl_frame_valid", hc_ctrl_frame_valid, m_ctrl_valid);
        check_frame("hc_ctrl_frame", hc_ctrl_frame, m_ctrl);
        check_frame("hc_read_frame", hc_read_frame, m_read);
        check_frame("hc_write_frame", hc_write_frame, m_write);
        check_word("hc_enable_test", t_csr_data'(hc_enable_test), '0);
    endtask

    task automatic write_frame(input t_csr_addr off, input t_frame_addr value,
                               input bit w_first, input int b_delay);
        axil_write(reg_addr(off + 8'h4), value[63:32], '1, w_first, b_delay);
        axil_write(reg_addr(off), value[31:0], '1, w_first, b_delay);
    endtask

    initial
    begin
        t_frame_addr v;
        t_csr_data d;
        t_csr_addr off;
        t_hc_enable_test mask;
        int i;
        clk = 1'b0;
        reset_n = 1'b0;
        s_awaddr = '0;
        s_awvalid = 1'b0;
        s_wdata = '0;
        s_wstrb = '0;
        s_wvalid = 1'b0;
        s_bready = 1'b0;
        s_araddr = '0;
        s_arvalid = 1'b0;
        s_rready = 1'b0;
        m_en = 1'b0;
        m_user = 1'b0;
        m_ctrl_valid = 1'b0;
        m_ctrl = '0;
        m_read = '0;
        m_write = '0;
        m_count = '0;
        errors = 0;
        checks = 0;
        err_mark = 0;
        pulse_prev = 1'b0;
        void'($urandom(49855));

        repeat (16) @(posedge clk);
        @(negedge clk);
        check_bit("s_awready", s_awready, 1'b0);
        check_bit("s_wready", s_wready, 1'b0);
        check_bit("s_arready", s_arready, 1'b0);
        @(posedge clk);
        #1;
        reset_n = 1'b1;

        // Only the reset registers are known here; the frames have no reset
        @(posedge clk);
        @(negedge clk);
        check_bit("s_awready", s_awready, 1'b1);
        check_bit("s_wready", s_wready, 1'b1);
        check_bit("s_arready", s_arready, 1'b1);
        check_bit("s_bvalid", s_bvalid, 1'b0);
        check_bit("s_rvalid", s_rvalid, 1'b0);
        check_bit("hc_en", hc_en, 1'b0);
        check_bit("hc_en_user_channel", hc_en_user_channel, 1'b0);
        check_bit("hc_ctrl_frame_valid", hc_ctrl_frame_valid, 1'b0);
        check_word("hc_enable_test", t_csr_data'(hc_enable_test), '0);
        read_and_check(reg_addr(`HC_CSR_EN), 0);
        read_and_check(reg_addr(`HC_CSR_ENABLE_TEST), 0);
        read_and_check(reg_addr(`HC_CSR_TEST_COUNT), 0);
        for (i = 0; i < 8; i++)
        begin
            axil_write(reg_addr(`HC_CSR_EN), $urandom(), '1, 1'b0, 0);
            @(negedge clk);
            check_bit("hc_en", hc_en, m_en);
            check_bit("hc_en_user_channel", hc_en_user_channel, m_user);
            read_and_check(reg_addr(`HC_CSR_EN), 0);
        end
        test_done("reset_and_enables");

        for (i = 0; i < 6; i++)
        begin
            v = {$urandom(), $urandom()};
            axil_write(reg_addr(`HC_CSR_CTRL_FRAME + 8'h4), v[63:32], '1, 1'b0, 0);
            @(negedge clk);
            check_bit("hc_ctrl_frame_valid", hc_ctrl_frame_valid, 1'b0);
            axil_write(reg_addr(`HC_CSR_CTRL_FRAME), v[31:0], '1, 1'b0, 0);
            @(negedge clk);
            check_bit("hc_ctrl_frame_valid", hc_ctrl_frame_valid, 1'b1);
            check_frame("hc_ctrl_frame", hc_ctrl_frame, v);
            read_and_check(reg_addr(`HC_CSR_CTRL_FRAME), 0);
            read_and_check(reg_addr(`HC_CSR_CTRL_FRAME + 8'h4), 0);
        end
        test_done("control_frame");

        for (i = 0; i < 6; i++)
        begin
            write_frame(`HC_CSR_READ_FRAME, {$urandom(), $urandom()}, 1'b0, 0);
            write_frame(`HC_CSR_WRITE_FRAME, {$urandom(), $urandom()}, 1'b0, 0);
            check_state();
        end
        // Partial strobes must leave every register as it was
        for (off = 0; off <= 8'h20; off += 4)
        begin
            axil_write(reg_addr(off), $urandom(), t_csr_strb'($urandom_range(0, 14)), 1'b0, 0);
        end
        check_state();
        check_all_regs(0);
        test_done("frames_and_strobes");

        pulses_seen.delete();
        for (i = 0; i < 9; i++)
        begin
            mask = (i == 8) ? '0 : t_hc_enable_test'($urandom_range(1, 255));
            d = $urandom();
            d[`HC_ENABLE_TEST_W-1:0] = mask;
            axil_write(reg_addr(`HC_CSR_ENABLE_TEST), d, '1, 1'b0, 0);
            repeat (3) @(posedge clk);
            #1;
            if (pulses_seen.size() != ((mask != '0) ? 1 : 0))
            begin
                errors++;
                $display("error at %0d ns: saw %0d test pulses for mask %h", $time,
                         pulses_seen.size(), mask);
            end
            else if (mask != '0)
            begin
                check_word("hc_enable_test", t_csr_data'(pulses_seen[0]), t_csr_data'(mask));
            end
            pulses_seen.delete();
            read_and_check(reg_addr(`HC_CSR_TEST_COUNT), 0);
        end
        test_done("test_pulse");

        read_and_check(reg_addr(8'h04), 0);
        read_and_check(reg_addr(8'h28), 1);
        read_and_check(reg_addr(8'h80), 0);
        read_and_check(reg_addr(8'hfc), 2);
        axil_write(reg_addr(8'h04), $urandom(), '1, 1'b0, 0);
        axil_write(reg_addr(8'h30), $urandom(), '1, 1'b1, 2);
        check_state();
        check_all_regs(0);
        for (i = 0; i < 12; i++)
        begin
            case ($urandom_range(0, 3))
                0: axil_write(reg_addr(`HC_CSR_EN), $urandom(), '1,
                              1'($urandom_range(0, 1)), $urandom_range(0, 5));
                1: write_frame(`HC_CSR_CTRL_FRAME, {$urandom(), $urandom()},
                               1'($urandom_range(0, 1)), $urandom_range(0, 5));
                2: write_frame(`HC_CSR_READ_FRAME, {$urandom(), $urandom()},
                               1'($urandom_range(0, 1)), $urandom_range(0, 5));
                default: write_frame(`HC_CSR_WRITE_FRAME, {$urandom(), $urandom()},
                                     1'($urandom_range(0, 1)), $urandom_range(0, 5));
            endcase
            check_state();
            check_all_regs($urandom_range(0, 5));
        end
        test_done("errors_and_backpressure");

        end_run();
    end

endmodule
